// ==== bp_pkg.sv ====
package bp_pkg;

    typedef logic [31:0] word_t;     // instruction address or target
    typedef logic [1:0]  ctr_t;      // saturating counter, msb predicts taken
    typedef logic [31:0] perf_t;     // performance counter value
    typedef logic [7:0]  reg_addr_t; // byte offset into the register block
    typedef logic [31:0] reg_data_t; // wishbone data word

    typedef enum logic [1:0] {
        kind_br,
        kind_jal,
        kind_jalr
    } cf_kind_t;

    typedef enum logic [1:0] {
        mode_tournament,
        mode_local,
        mode_global
    } pred_mode_t;

    // counter states
    localparam ctr_t CTR_STRONG_NT = 2'b00;
    localparam ctr_t CTR_WEAK_NT   = 2'b01;    // reset value of every counter
    localparam ctr_t CTR_STRONG_T  = 2'b11;

    localparam pred_mode_t MODE_RESET = mode_tournament;

    localparam int DEF_HISTORY_DEPTH       = 8;
    localparam int DEF_LHT_INDEX_WIDTH     = 6;
    localparam int DEF_CHOOSER_INDEX_WIDTH = 6;
    localparam int DEF_BTB_INDEX_WIDTH     = 5;

    // register map
    localparam reg_addr_t REG_MODE          = 8'h00;
    localparam reg_addr_t REG_CF_COUNT      = 8'h04;
    localparam reg_addr_t REG_BR_COUNT      = 8'h08;
    localparam reg_addr_t REG_CORRECT_COUNT = 8'h0c;
    localparam reg_addr_t REG_STATUS        = 8'h10;

    // overflow bits in REG_STATUS, also the counter slots in the csr block
    localparam int STATUS_CF_OVF      = 0;
    localparam int STATUS_BR_OVF      = 1;
    localparam int STATUS_CORRECT_OVF = 2;

endpackage : bp_pkg

// ==== pattern_table.sv ====
`timescale 1ns/1ps

module pattern_table
    import bp_pkg::*;
#(
    parameter int INDEX_WIDTH = 8
)
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic [INDEX_WIDTH-1:0] rd_index,
    output logic                   rd_taken,
    input  logic [INDEX_WIDTH-1:0] wr_index,
    input  logic                   wr_en,
    input  logic                   wr_taken,
    output logic                   wr_side_taken
);

    localparam int ENTRIES = 1 << INDEX_WIDTH;

    ctr_t ctr_q [ENTRIES];
    ctr_t wr_cur;
    ctr_t wr_next;

    assign rd_taken      = ctr_q[rd_index][1];
    assign wr_cur        = ctr_q[wr_index];
    assign wr_side_taken = wr_cur[1];      // state before this update

    always_comb begin
        wr_next = wr_cur;
        if (wr_taken && wr_cur != CTR_STRONG_T) begin
            wr_next = wr_cur + 2'd1;
        end else if (!wr_taken && wr_cur != CTR_STRONG_NT) begin
            wr_next = wr_cur - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ENTRIES; i++) begin
                ctr_q[i] <= CTR_WEAK_NT;
            end
        end else if (wr_en) begin
            ctr_q[wr_index] <= wr_next;
        end
    end

endmodule : pattern_table

// ==== local_history_table.sv ====
`timescale 1ns/1ps

module local_history_table
    import bp_pkg::*;
#(
    parameter int INDEX_WIDTH   = 6,
    parameter int HISTORY_DEPTH = 8
)
(
    input  logic                     clk,
    input  logic                     reset,
    input  word_t                    rd_pc,
    output logic [HISTORY_DEPTH-1:0] rd_hist,
    input  word_t                    wr_pc,
    input  logic                     wr_en,
    input  logic                     wr_taken
);

    localparam int ENTRIES = 1 << INDEX_WIDTH;

    logic [HISTORY_DEPTH-1:0] hist_q [ENTRIES];
    logic [INDEX_WIDTH-1:0]   rd_idx;
    logic [INDEX_WIDTH-1:0]   wr_idx;

    // word aligned pcs, skip the low two bits
    assign rd_idx  = rd_pc[INDEX_WIDTH+1:2];
    assign wr_idx  = wr_pc[INDEX_WIDTH+1:2];
    assign rd_hist = hist_q[rd_idx];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ENTRIES; i++) begin
                hist_q[i] <= '0;
            end
        end else if (wr_en) begin
            hist_q[wr_idx] <= {hist_q[wr_idx][HISTORY_DEPTH-2:0], wr_taken}; // newest in lsb
        end
    end

endmodule : local_history_table

// ==== branch_target_buffer.sv ====
`timescale 1ns/1ps

module branch_target_buffer
    import bp_pkg::*;
#(
    parameter int INDEX_WIDTH = 5
)
(
    input  logic     clk,
    input  logic     reset,
    input  word_t    lookup_pc,
    output logic     hit,
    output word_t    target,
    output cf_kind_t kind,
    input  logic     fill_en,
    input  word_t    fill_pc,
    input  word_t    fill_target,
    input  cf_kind_t fill_kind
);

    localparam int ENTRIES   = 1 << INDEX_WIDTH;
    localparam int TAG_WIDTH = 30 - INDEX_WIDTH;

    logic [ENTRIES-1:0]   valid_q;
    logic [TAG_WIDTH-1:0] tag_q    [ENTRIES];
    word_t                target_q [ENTRIES];
    cf_kind_t             kind_q   [ENTRIES];

    logic [INDEX_WIDTH-1:0] lk_idx;
    logic [TAG_WIDTH-1:0]   lk_tag;
    logic [INDEX_WIDTH-1:0] fill_idx;
    word_t                  fill_word;

    assign lk_idx   = lookup_pc[INDEX_WIDTH+1:2];
    assign lk_tag   = lookup_pc[31:INDEX_WIDTH+2];
    assign fill_idx = fill_pc[INDEX_WIDTH+1:2];

    assign hit    = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);
    assign target = target_q[lk_idx];
    assign kind   = kind_q[lk_idx];

    // jalr targets come from rs1 + imm, lsb is dropped
    assign fill_word = (fill_kind == kind_jalr) ? {fill_target[31:1], 1'b0} : fill_target;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (fill_en) begin
            valid_q[fill_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_q[fill_idx]    <= fill_pc[31:INDEX_WIDTH+2];
            target_q[fill_idx] <= fill_word;
            kind_q[fill_idx]   <= fill_kind;  // older entry at this index is lost
        end
    end

endmodule : branch_target_buffer

// ==== tournament_predictor.sv ====
`timescale 1ns/1ps

module tournament_predictor
    import bp_pkg::*;
#(
    parameter int HISTORY_DEPTH       = 8,
    parameter int LHT_INDEX_WIDTH     = 6,
    parameter int CHOOSER_INDEX_WIDTH = 6
)
(
    input  logic                     clk,
    input  logic                     reset,
    input  pred_mode_t               mode,
    input  word_t                    lookup_pc,
    output logic                     dir_taken,
    output logic [HISTORY_DEPTH-1:0] ghist,
    output logic [HISTORY_DEPTH-1:0] lhist,
    input  logic                     upd_br,
    input  word_t                    upd_pc,
    input  logic                     upd_taken,
    input  logic [HISTORY_DEPTH-1:0] upd_ghist,
    input  logic [HISTORY_DEPTH-1:0] upd_lhist
);

    logic [HISTORY_DEPTH-1:0] ghr_q;

    logic global_taken;
    logic local_taken;
    logic chooser_global;   // msb set picks global
    logic global_side;
    logic local_side;
    logic chooser_en;
    logic chooser_toward_global;

    assign ghist = ghr_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            ghr_q <= '0;
        end else if (upd_br) begin
            ghr_q <= {ghr_q[HISTORY_DEPTH-2:0], upd_taken};
        end
    end

    local_history_table #(
        .INDEX_WIDTH   (LHT_INDEX_WIDTH),
        .HISTORY_DEPTH (HISTORY_DEPTH)
    ) lht (
        .clk      (clk),
        .reset    (reset),
        .rd_pc    (lookup_pc),
        .rd_hist  (lhist),
        .wr_pc    (upd_pc),
        .wr_en    (upd_br),
        .wr_taken (upd_taken)
    );

    pattern_table #(.INDEX_WIDTH(HISTORY_DEPTH)) global_pht (
        .clk           (clk),
        .reset         (reset),
        .rd_index      (ghr_q),
        .rd_taken      (global_taken),
        .wr_index      (upd_ghist),     // history the fetch stage saw
        .wr_en         (upd_br),
        .wr_taken      (upd_taken),
        .wr_side_taken (global_side)
    );

    pattern_table #(.INDEX_WIDTH(HISTORY_DEPTH)) local_pht (
        .clk           (clk),
        .reset         (reset),
        .rd_index      (lhist),
        .rd_taken      (local_taken),
        .wr_index      (upd_lhist),
        .wr_en         (upd_br),
        .wr_taken      (upd_taken),
        .wr_side_taken (local_side)
    );

    // train the chooser only when the two tables disagreed
    assign chooser_en            = upd_br && (global_side != local_side);
    assign chooser_toward_global = (global_side == upd_taken);

    pattern_table #(.INDEX_WIDTH(CHOOSER_INDEX_WIDTH)) chooser_pht (
        .clk           (clk),
        .reset         (reset),
        .rd_index      (lookup_pc[CHOOSER_INDEX_WIDTH+1:2]),
        .rd_taken      (chooser_global),
        .wr_index      (upd_pc[CHOOSER_INDEX_WIDTH+1:2]),
        .wr_en         (chooser_en),
        .wr_taken      (chooser_toward_global),
        .wr_side_taken ()
    );

    always_comb begin
        case (mode)
            mode_local:  dir_taken = local_taken;
            mode_global: dir_taken = global_taken;
            default:     dir_taken = chooser_global ? global_taken : local_taken;
        endcase
    end

endmodule : tournament_predictor

// ==== bp_csr.sv ====
`timescale 1ns/1ps

module bp_csr
    import bp_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  reg_addr_t  wb_adr,
    input  reg_data_t  wb_dat_w,
    output reg_data_t  wb_dat_r,
    output logic       wb_ack,
    input  logic       upd_valid,
    input  cf_kind_t   upd_kind,
    input  logic       upd_taken,
    input  logic       upd_pred_taken,
    output pred_mode_t mode
);

    localparam int NUM_CNT = 3;

    perf_t        count_q [NUM_CNT];
    logic [2:0]   ovf_q;          // sticky wrap flags
    logic [2:0]   inc;
    logic         accept;
    logic         wr_mode;
    logic         clear_cnt;
    reg_data_t    rd_data;

    // one access per ack, so ack low marks a fresh request
    assign accept    = wb_cyc && wb_stb && !wb_ack;
    assign wr_mode   = accept && wb_we && (wb_adr == REG_MODE);
    assign clear_cnt = accept && wb_we && (wb_adr == REG_CF_COUNT ||
                                           wb_adr == REG_BR_COUNT ||
                                           wb_adr == REG_CORRECT_COUNT);

    assign inc[STATUS_CF_OVF]      = upd_valid;
    assign inc[STATUS_BR_OVF]      = upd_valid && (upd_kind == kind_br);
    assign inc[STATUS_CORRECT_OVF] = inc[STATUS_BR_OVF] && (upd_pred_taken == upd_taken);

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mode <= MODE_RESET;
        end else if (wr_mode && wb_dat_w[1:0] != 2'b11) begin
            mode <= pred_mode_t'(wb_dat_w[1:0]);   // encoding 3 is reserved
        end
    end

    always_ff @(posedge clk) begin
        if (reset || clear_cnt) begin
            for (int i = 0; i < NUM_CNT; i++) begin
                count_q[i] <= '0;
            end
            ovf_q <= '0;
        end else begin
            for (int i = 0; i < NUM_CNT; i++) begin
                if (inc[i]) begin
                    count_q[i] <= count_q[i] + 1'b1;
                    if (&count_q[i]) begin
                        ovf_q[i] <= 1'b1;   // about to wrap
                    end
                end
            end
        end
    end

    always_comb begin
        rd_data = '0;
        case (wb_adr)
            REG_MODE:          rd_data = {30'b0, mode};
            REG_CF_COUNT:      rd_data = count_q[STATUS_CF_OVF];
            REG_BR_COUNT:      rd_data = count_q[STATUS_BR_OVF];
            REG_CORRECT_COUNT: rd_data = count_q[STATUS_CORRECT_OVF];
            REG_STATUS:        rd_data = {29'b0, ovf_q};
            default:           rd_data = '0;
        endcase
    end

    // captured with the access, valid while ack is high
    always_ff @(posedge clk) begin
        if (accept) begin
            wb_dat_r <= rd_data;
        end
    end

endmodule : bp_csr

// ==== bp_top.sv ====
`timescale 1ns/1ps

module bp_top
    import bp_pkg::*;
#(
    parameter int HISTORY_DEPTH       = DEF_HISTORY_DEPTH,
    parameter int LHT_INDEX_WIDTH     = DEF_LHT_INDEX_WIDTH,
    parameter int CHOOSER_INDEX_WIDTH = DEF_CHOOSER_INDEX_WIDTH,
    parameter int BTB_INDEX_WIDTH     = DEF_BTB_INDEX_WIDTH
)
(
    input  logic                     clk,
    input  logic                     reset,

    // lookup from fetch
    input  word_t                    lookup_pc,
    output logic                     pred_hit,
    output logic                     pred_taken,
    output word_t                    pred_target,
    output cf_kind_t                 pred_kind,
    output logic [HISTORY_DEPTH-1:0] pred_ghist,
    output logic [HISTORY_DEPTH-1:0] pred_lhist,

    // resolved outcome from execute
    input  logic                     upd_valid,
    input  word_t                    upd_pc,
    input  cf_kind_t                 upd_kind,
    input  logic                     upd_taken,
    input  word_t                    upd_target,
    input  logic                     upd_pred_taken,
    input  logic [HISTORY_DEPTH-1:0] upd_ghist,
    input  logic [HISTORY_DEPTH-1:0] upd_lhist,

    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  reg_addr_t                wb_adr,
    input  reg_data_t                wb_dat_w,
    output reg_data_t                wb_dat_r,
    output logic                     wb_ack
);

    pred_mode_t mode;
    logic       dir_taken;
    logic       upd_br;
    logic       fill_en;

    assign upd_br  = upd_valid && (upd_kind == kind_br);
    assign fill_en = upd_valid && (upd_taken || upd_kind != kind_br);  // jumps always fill

    // jumps are always taken, branches follow the direction predictor
    assign pred_taken = pred_hit && (pred_kind != kind_br || dir_taken);

    tournament_predictor #(
        .HISTORY_DEPTH       (HISTORY_DEPTH),
        .LHT_INDEX_WIDTH     (LHT_INDEX_WIDTH),
        .CHOOSER_INDEX_WIDTH (CHOOSER_INDEX_WIDTH)
    ) predictor (
        .clk       (clk),
        .reset     (reset),
        .mode      (mode),
        .lookup_pc (lookup_pc),
        .dir_taken (dir_taken),
        .ghist     (pred_ghist),
        .lhist     (pred_lhist),
        .upd_br    (upd_br),
        .upd_pc    (upd_pc),
        .upd_taken (upd_taken),
        .upd_ghist (upd_ghist),
        .upd_lhist (upd_lhist)
    );

    branch_target_buffer #(.INDEX_WIDTH(BTB_INDEX_WIDTH)) btb (
        .clk         (clk),
        .reset       (reset),
        .lookup_pc   (lookup_pc),
        .hit         (pred_hit),
        .target      (pred_target),
        .kind        (pred_kind),
        .fill_en     (fill_en),
        .fill_pc     (upd_pc),
        .fill_target (upd_target),
        .fill_kind   (upd_kind)
    );

    bp_csr csr (
        .clk            (clk),
        .reset          (reset),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_w       (wb_dat_w),
        .wb_dat_r       (wb_dat_r),
        .wb_ack         (wb_ack),
        .upd_valid      (upd_valid),
        .upd_kind       (upd_kind),
        .upd_taken      (upd_taken),
        .upd_pred_taken (upd_pred_taken),
        .mode           (mode)
    );

endmodule : bp_top

// ==== bp_tb.sv ====
`timescale 1ns/1ps

module bp_tb
    import bp_pkg::*;
;

    localparam int CLK_PERIOD  = 100;
    localparam int HD          = DEF_HISTORY_DEPTH;
    localparam int BTB_W       = DEF_BTB_INDEX_WIDTH;
    localparam int BTB_ENTRIES = 1 << BTB_W;
    localparam int LHT_W       = DEF_LHT_INDEX_WIDTH;
    localparam int LHT_ENTRIES = 1 << LHT_W;
    localparam int ACK_LIMIT   = 20;        // cycles to wait for wb_ack

    typedef logic [HD-1:0] hist_t;

    logic clk;
    logic reset;
    word_t lookup_pc;
    logic pred_hit;
    logic pred_taken;
    word_t pred_target;
    cf_kind_t pred_kind;
    hist_t pred_ghist;
    hist_t pred_lhist;
    logic upd_valid;
    word_t upd_pc;
    cf_kind_t upd_kind;
    logic upd_taken;
    word_t upd_target;
    logic upd_pred_taken;
    hist_t upd_ghist;
    hist_t upd_lhist;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    reg_addr_t wb_adr;
    reg_data_t wb_dat_w;
    reg_data_t wb_dat_r;
    logic wb_ack;

    integer seed;
    int value_errors;
    int protocol_errors;
    int timeouts;
    int exp_cf;
    int exp_br;
    int exp_correct;

    // mirror of the target buffer
    logic     m_valid  [BTB_ENTRIES];
    word_t    m_pc     [BTB_ENTRIES];
    word_t    m_target [BTB_ENTRIES];
    cf_kind_t m_kind   [BTB_ENTRIES];

    // expected histories, newest outcome in the lsb
    hist_t    m_ghist;
    hist_t    m_lhist  [LHT_ENTRIES];

    bp_top #(
        .HISTORY_DEPTH       (DEF_HISTORY_DEPTH),
        .LHT_INDEX_WIDTH     (DEF_LHT_INDEX_WIDTH),
        .CHOOSER_INDEX_WIDTH (DEF_CHOOSER_INDEX_WIDTH),
        .BTB_INDEX_WIDTH     (DEF_BTB_INDEX_WIDTH)
    ) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    ack_after_request: assert property (@(posedge clk) disable iff (reset)
        wb_ack |-> $past(wb_cyc && wb_stb))
    else begin
        protocol_errors++;
        $display("Error at %0t: wb_ack without a request in the cycle before", $time);
    end

    ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
        wb_ack |-> !$past(wb_ack))
    else begin
        protocol_errors++;
        $display("Error at %0t: wb_ack high for two cycles in a row", $time);
    end

    function automatic word_t random_pc();
        random_pc = $random(seed) & 32'hffff_fffc;   // word aligned
    endfunction

    task automatic expect_value(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp)
        else begin
            value_errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic wait_ack();
        int waited;
        waited = 0;
        while (!wb_ack && waited < ACK_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!wb_ack) begin
            timeouts++;
            $display("Timeout at %0t: the register block never acknowledged the access", $time);
        end
    endtask

    task automatic wb_write(input reg_addr_t adr, input reg_data_t data);
        @(negedge clk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = 1'b1;
        wb_adr = adr;
        wb_dat_w = data;
        wait_ack();
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic wb_read_expect(input reg_addr_t adr, input reg_data_t exp);
        reg_data_t data;
        @(negedge clk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = 1'b0;
        wb_adr = adr;
        wait_ack();
        data = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        expect_value($sformatf("register %h", adr), data, exp);
    endtask

    // outputs are read a quarter period after the pc changes
    task automatic do_lookup(input word_t pc);
        @(negedge clk);
        lookup_pc = pc;
        #(CLK_PERIOD/4);
    endtask

    task automatic send_update(input word_t pc, input cf_kind_t kind, input logic taken,
                               input word_t target, input logic pred,
                               input hist_t gh, input hist_t lh);
        int idx;
        int lidx;
        idx = int'(pc[BTB_W+1:2]);
        lidx = int'(pc[LHT_W+1:2]);
        @(negedge clk);
        upd_valid = 1'b1;
        upd_pc = pc;
        upd_kind = kind;
        upd_taken = taken;
        upd_target = target;
        upd_pred_taken = pred;
        upd_ghist = gh;
        upd_lhist = lh;
        if (taken || kind != kind_br) begin
            m_valid[idx] = 1'b1;
            m_pc[idx] = pc;
            m_target[idx] = (kind == kind_jalr) ? {target[31:1], 1'b0} : target;
            m_kind[idx] = kind;
        end
        exp_cf++;
        if (kind == kind_br) begin
            exp_br++;
            if (pred == taken) exp_correct++;
            m_ghist = {m_ghist[HD-2:0], taken};
            m_lhist[lidx] = {m_lhist[lidx][HD-2:0], taken};
        end
        @(negedge clk);
        upd_valid = 1'b0;
    endtask

    task automatic check_lookup(input word_t pc);
        int idx;
        int lidx;
        logic exp_hit;
        idx = int'(pc[BTB_W+1:2]);
        lidx = int'(pc[LHT_W+1:2]);
        exp_hit = m_valid[idx] && (m_pc[idx][31:BTB_W+2] == pc[31:BTB_W+2]);
        do_lookup(pc);
        expect_value("pred_hit", 32'(pred_hit), 32'(exp_hit));
        expect_value("pred_ghist", 32'(pred_ghist), 32'(m_ghist));
        expect_value("pred_lhist", 32'(pred_lhist), 32'(m_lhist[lidx]));
        if (exp_hit) begin
            expect_value("pred_target", pred_target, m_target[idx]);
            expect_value("pred_kind", 32'(pred_kind), 32'(m_kind[idx]));
            if (m_kind[idx] != kind_br) expect_value("pred_taken", 32'(pred_taken), 32'd1);
        end else begin
            expect_value("pred_taken", 32'(pred_taken), 32'd0);
        end
    endtask

    initial begin
        word_t pc_a;
        word_t pc_b;
        word_t pc_c;
        word_t pc_p;
        logic [1:0] kbits;
        logic taken;
        seed = 32'h2a17;
        value_errors = 0;
        protocol_errors = 0;
        timeouts = 0;
        exp_cf = 0;
        exp_br = 0;
        exp_correct = 0;
        for (int i = 0; i < BTB_ENTRIES; i++) m_valid[i] = 1'b0;
        m_ghist = '0;
        for (int i = 0; i < LHT_ENTRIES; i++) m_lhist[i] = '0;
        reset = 1'b1;
        lookup_pc = '0;
        upd_valid = 1'b0;
        upd_pc = '0;
        upd_kind = kind_br;
        upd_taken = 1'b0;
        upd_target = '0;
        upd_pred_taken = 1'b0;
        upd_ghist = '0;
        upd_lhist = '0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // empty buffer, zeroed registers
        for (int i = 0; i < 8; i++) check_lookup(random_pc());
        wb_read_expect(REG_MODE, 32'(mode_tournament));
        wb_read_expect(REG_CF_COUNT, 32'd0);
        wb_read_expect(REG_BR_COUNT, 32'd0);
        wb_read_expect(REG_CORRECT_COUNT, 32'd0);
        wb_read_expect(REG_STATUS, 32'd0);
        wb_read_expect(8'h14, 32'd0);

        // jal and jalr entries, then an alias at the same index
        pc_a = random_pc();
        pc_b = pc_a + 32'd4;
        pc_c = pc_a + (32'd1 << (BTB_W + 2));
        send_update(pc_a, kind_jal, 1'b1, random_pc(), 1'b0, '0, '0);
        send_update(pc_b, kind_jalr, 1'b1, random_pc() | 32'd1, 1'b0, '0, '0);
        check_lookup(pc_a);
        check_lookup(pc_b);
        send_update(pc_c, kind_jal, 1'b1, random_pc(), 1'b0, '0, '0);
        check_lookup(pc_c);
        check_lookup(pc_a);

        // train one branch taken with the histories seen at fetch
        pc_p = random_pc();
        for (int i = 0; i < HD + 2; i++) begin
            do_lookup(pc_p);
            send_update(pc_p, kind_br, 1'b1, pc_p + 32'd64, pred_taken, pred_ghist, pred_lhist);
        end
        for (int m = 2; m >= 0; m--) begin
            wb_write(REG_MODE, 32'(m));
            wb_read_expect(REG_MODE, 32'(m));
            check_lookup(pc_p);
            expect_value($sformatf("trained pred_taken, mode %0d", m), 32'(pred_taken), 32'd1);
        end
        wb_write(REG_MODE, 32'(mode_global));
        for (int i = 0; i < 4; i++) begin
            do_lookup(pc_p);
            send_update(pc_p, kind_br, 1'b0, pc_p + 32'd64, pred_taken, pred_ghist, pred_lhist);
        end
        do_lookup(pc_p);
        expect_value("global pred_taken after not taken", 32'(pred_taken), 32'd0);
        wb_write(REG_MODE, 32'(mode_tournament));

        // random mix for the counters
        for (int i = 0; i < 40; i++) begin
            kbits = 2'({$random(seed)} % 3);
            taken = (kbits == 2'd0) ? 1'($random(seed)) : 1'b1;
            send_update(random_pc(), cf_kind_t'(kbits), taken, random_pc(),
                        1'($random(seed)), hist_t'($random(seed)), hist_t'($random(seed)));
        end
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            if (m_valid[i]) check_lookup(m_pc[i]);
        end
        wb_read_expect(REG_CF_COUNT, 32'(exp_cf));
        wb_read_expect(REG_BR_COUNT, 32'(exp_br));
        wb_read_expect(REG_CORRECT_COUNT, 32'(exp_correct));
        wb_read_expect(REG_STATUS, 32'd0);
        wb_write(REG_CF_COUNT, 32'd0);   // clears all three
        wb_read_expect(REG_CF_COUNT, 32'd0);
        wb_read_expect(REG_BR_COUNT, 32'd0);
        wb_read_expect(REG_CORRECT_COUNT, 32'd0);
        wb_read_expect(8'h20, 32'd0);
        wb_read_expect(8'hfc, 32'd0);

        repeat (2) @(negedge clk);
        $display("errors: value %0d, protocol %0d, timeout %0d",
                 value_errors, protocol_errors, timeouts);
        if (value_errors + protocol_errors + timeouts == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule : bp_tb

// ==== flist.f ====
bp_pkg.sv
pattern_table.sv
local_history_table.sv
branch_target_buffer.sv
tournament_predictor.sv
bp_csr.sv
bp_top.sv
bp_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the branch predictor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module bp_tb -o bp_sim

output=$(./obj_dir/bp_sim)
echo "$output"

if grep -qx "STATUS: PASS" <<< "$output"; then
    exit 0
fi
exit 1
